// File: rx_frontend_pkg.sv
/* Receive front end shared types */
package rx_frontend_pkg;

  // Raw ADC and output sample width
  localparam int ADC_WIDTH = 16;

  // Internal datapath width, Q1.23
  localparam int DSP_WIDTH = 24;

  // Correction coefficient width, Q1.17
  localparam int COEF_WIDTH = 18;

  // Settings bus
  localparam int SET_ADDR_WIDTH = 8;
  localparam int SET_DATA_WIDTH = 32;

  // 16-bit signed sample at the ADC and at the output
  typedef logic signed [ADC_WIDTH-1:0] adc_sample_t;

  // 24-bit signed sample inside the DSP chain
  typedef logic signed [DSP_WIDTH-1:0] dsp_sample_t;

  // Magnitude and phase coefficient
  typedef logic signed [COEF_WIDTH-1:0] coef_t;

  typedef logic [SET_ADDR_WIDTH-1:0] set_addr_t;
  typedef logic [SET_DATA_WIDTH-1:0] set_data_t;

  // DC offset integrator mode
  typedef enum logic {
    DCO_TRACK = 1'b0,
    DCO_FIXED = 1'b1
  } dco_state_t;

endpackage

// File: setting_reg.sv
/* Settings bus register */
`timescale 1ns/1ps

module setting_reg #(
  parameter rx_frontend_pkg::set_addr_t MY_ADDR = '0,
  parameter int WIDTH = 32
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       set_stb_i,
  input  rx_frontend_pkg::set_addr_t set_addr_i,
  input  rx_frontend_pkg::set_data_t set_data_i,
  output logic [WIDTH-1:0]           value_o,
  output logic                       changed_o
);

  logic hit;

  assign hit = set_stb_i && (set_addr_i == MY_ADDR);

  // Value holds until the next write to this address
  always_ff @(posedge clk) begin
    if (reset) begin
      value_o   <= '0;
      changed_o <= 1'b0;
    end else begin
      changed_o <= hit;
      if (hit) begin
        value_o <= set_data_i[WIDTH-1:0];
      end
    end
  end

endmodule

// File: rx_iq_map.sv
/* I/Q swap, inversion and real mode */
`timescale 1ns/1ps

module rx_iq_map (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stb_i,
  input  rx_frontend_pkg::adc_sample_t i_i,
  input  rx_frontend_pkg::adc_sample_t q_i,
  input  logic                         swap_i,
  input  logic                         realmode_i,
  input  logic                         invert_i_i,
  input  logic                         invert_q_i,
  output logic                         stb_o,
  output rx_frontend_pkg::dsp_sample_t i_o,
  output rx_frontend_pkg::dsp_sample_t q_o
);

  import rx_frontend_pkg::*;

  adc_sample_t i_inv;
  adc_sample_t q_inv;
  adc_sample_t i_sel;
  adc_sample_t q_sel;

  // Each channel keeps its own inversion, even when swapped
  assign i_inv = invert_i_i ? ~i_i : i_i;
  assign q_inv = invert_q_i ? ~q_i : q_i;

  assign i_sel = swap_i ? q_inv : i_inv;
  // Real mode forces Q to zero
  assign q_sel = realmode_i ? '0 : (swap_i ? i_inv : q_inv);

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  // Widen to Q1.23 with the low bits cleared
  always_ff @(posedge clk) begin
    i_o <= {i_sel, {(DSP_WIDTH - ADC_WIDTH){1'b0}}};
    q_o <= {q_sel, {(DSP_WIDTH - ADC_WIDTH){1'b0}}};
  end

endmodule

// File: rx_dcoffset.sv
/* DC offset removal, one lane */
`timescale 1ns/1ps

module rx_dcoffset #(
  parameter int WIDTH = 24,
  parameter int ALPHA_SHIFT = 12
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         set_changed_i,
  input  rx_frontend_pkg::set_data_t   set_value_i,
  input  logic                         stb_i,
  input  rx_frontend_pkg::dsp_sample_t sample_i,
  output logic                         stb_o,
  output rx_frontend_pkg::dsp_sample_t sample_o
);

  import rx_frontend_pkg::*;

  localparam int INT_W = WIDTH + ALPHA_SHIFT;

  logic signed [INT_W-1:0] integ;
  logic signed [WIDTH-1:0] integ_top;
  logic signed [WIDTH:0]   diff;
  dsp_sample_t             sat_out;
  dsp_sample_t             set_offset;
  dco_state_t              mode;

  // Offset field of the settings word
  assign set_offset = set_value_i[29 -: DSP_WIDTH];

  // Current DC estimate
  assign integ_top = integ[INT_W-1 -: WIDTH];

  assign diff = sample_i - integ_top;

  // Clip the corrected sample to the signed range
  always_comb begin
    if (diff[WIDTH:WIDTH-1] == 2'b01) begin
      sat_out = {1'b0, {(WIDTH-1){1'b1}}};
    end else if (diff[WIDTH:WIDTH-1] == 2'b10) begin
      sat_out = {1'b1, {(WIDTH-1){1'b0}}};
    end else begin
      sat_out = diff[WIDTH-1:0];
    end
  end

  // A settings write wins over the tracking update
  always_ff @(posedge clk) begin
    if (reset) begin
      integ <= '0;
      mode  <= DCO_TRACK;
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
      if (set_changed_i) begin
        integ <= INT_W'(set_offset) <<< ALPHA_SHIFT;
        mode  <= set_value_i[31] ? DCO_FIXED : DCO_TRACK;
      end else if (stb_i && (mode == DCO_TRACK)) begin
        // Leaky average of the residual, time constant 2^ALPHA_SHIFT
        integ <= integ + INT_W'(sat_out);
      end
    end
  end

  always_ff @(posedge clk) begin
    sample_o <= sat_out;
  end

endmodule

// File: rx_iq_comp.sv
/* I/Q imbalance multiply-add-clip, one lane */
`timescale 1ns/1ps

module rx_iq_comp (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stb_i,
  input  rx_frontend_pkg::dsp_sample_t a_i,
  input  rx_frontend_pkg::coef_t       coef_i,
  input  rx_frontend_pkg::dsp_sample_t c_i,
  output logic                         stb_o,
  output rx_frontend_pkg::dsp_sample_t sample_o
);

  import rx_frontend_pkg::*;

  localparam int PROD_W = 2 * COEF_WIDTH;
  localparam int SUM_W  = PROD_W + 1;
  // Q2.34 product down to the Q1.23 grid of c
  localparam int PROD_SHIFT = 2 * (COEF_WIDTH - 1) - (DSP_WIDTH - 1);

  logic signed [COEF_WIDTH-1:0] a_top;
  logic signed [PROD_W-1:0]     prod_q;
  dsp_sample_t                  c_q;
  logic                         stb_q;
  logic signed [SUM_W-1:0]      sum;
  dsp_sample_t                  clip;

  assign a_top = a_i[DSP_WIDTH-1 -: COEF_WIDTH];

  // Stage one
  always_ff @(posedge clk) begin
    prod_q <= a_top * coef_i;
    c_q    <= c_i;
  end

  // Arithmetic shift floors toward minus infinity
  assign sum = c_q + (prod_q >>> PROD_SHIFT);

  always_comb begin
    if (sum[SUM_W-1:DSP_WIDTH-1] == {(SUM_W - DSP_WIDTH + 1){sum[SUM_W-1]}}) begin
      clip = sum[DSP_WIDTH-1:0];
    end else if (sum[SUM_W-1]) begin
      clip = {1'b1, {(DSP_WIDTH-1){1'b0}}};
    end else begin
      clip = {1'b0, {(DSP_WIDTH-1){1'b1}}};
    end
  end

  // Stage two
  always_ff @(posedge clk) begin
    sample_o <= clip;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_q <= 1'b0;
      stb_o <= 1'b0;
    end else begin
      stb_q <= stb_i;
      stb_o <= stb_q;
    end
  end

endmodule

// File: rx_round.sv
/* Round 24 to 16 bits with saturation */
`timescale 1ns/1ps

module rx_round (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stb_i,
  input  rx_frontend_pkg::dsp_sample_t sample_i,
  output logic                         stb_o,
  output rx_frontend_pkg::adc_sample_t sample_o
);

  import rx_frontend_pkg::*;

  localparam int DROP = DSP_WIDTH - ADC_WIDTH;

  logic signed [DSP_WIDTH:0]  biased;
  logic signed [ADC_WIDTH:0]  shifted;
  adc_sample_t                rounded;

  // Half an output LSB, then truncate: round half up
  assign biased  = sample_i + (1 <<< (DROP - 1));
  assign shifted = biased[DSP_WIDTH:DROP];

  always_comb begin
    if (shifted[ADC_WIDTH:ADC_WIDTH-1] == 2'b01) begin
      rounded = {1'b0, {(ADC_WIDTH-1){1'b1}}};
    end else if (shifted[ADC_WIDTH:ADC_WIDTH-1] == 2'b10) begin
      rounded = {1'b1, {(ADC_WIDTH-1){1'b0}}};
    end else begin
      rounded = shifted[ADC_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  always_ff @(posedge clk) begin
    sample_o <= rounded;
  end

endmodule

// File: rx_frontend.sv
/* Receive front end top */
`timescale 1ns/1ps

module rx_frontend #(
  parameter int SR_MAG_CORRECTION   = 0,
  parameter int SR_PHASE_CORRECTION = 1,
  parameter int SR_OFFSET_I         = 2,
  parameter int SR_OFFSET_Q         = 3,
  parameter int SR_IQ_MAPPING       = 4,
  parameter int ALPHA_SHIFT         = 12
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         set_stb_i,
  input  rx_frontend_pkg::set_addr_t   set_addr_i,
  input  rx_frontend_pkg::set_data_t   set_data_i,
  input  logic                         adc_stb_i,
  input  rx_frontend_pkg::adc_sample_t adc_i_i,
  input  rx_frontend_pkg::adc_sample_t adc_q_i,
  output logic                         rx_stb_o,
  output rx_frontend_pkg::adc_sample_t rx_i_o,
  output rx_frontend_pkg::adc_sample_t rx_q_o
);

  import rx_frontend_pkg::*;

  coef_t       mag_corr;
  coef_t       phase_corr;
  logic [3:0]  iq_map;
  set_data_t   offset_i;
  set_data_t   offset_q;
  logic        offset_i_changed;
  logic        offset_q_changed;

  logic        map_stb;
  dsp_sample_t map_i;
  dsp_sample_t map_q;
  logic        ofs_stb;
  dsp_sample_t ofs_i;
  dsp_sample_t ofs_q;
  logic        comp_stb;
  dsp_sample_t comp_i;
  dsp_sample_t comp_q;

  // Settings registers
  setting_reg #(.MY_ADDR(SR_MAG_CORRECTION), .WIDTH(COEF_WIDTH)) sr_mag (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .value_o(mag_corr), .changed_o());

  setting_reg #(.MY_ADDR(SR_PHASE_CORRECTION), .WIDTH(COEF_WIDTH)) sr_phase (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .value_o(phase_corr), .changed_o());

  // Bits: 0 swap, 1 real mode, 2 invert Q, 3 invert I
  setting_reg #(.MY_ADDR(SR_IQ_MAPPING), .WIDTH(4)) sr_map (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .value_o(iq_map), .changed_o());

  setting_reg #(.MY_ADDR(SR_OFFSET_I), .WIDTH(SET_DATA_WIDTH)) sr_ofs_i (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .value_o(offset_i), .changed_o(offset_i_changed));

  setting_reg #(.MY_ADDR(SR_OFFSET_Q), .WIDTH(SET_DATA_WIDTH)) sr_ofs_q (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .value_o(offset_q), .changed_o(offset_q_changed));

  rx_iq_map u_map (
    .clk(clk), .reset(reset), .stb_i(adc_stb_i), .i_i(adc_i_i), .q_i(adc_q_i),
    .swap_i(iq_map[0]), .realmode_i(iq_map[1]), .invert_i_i(iq_map[3]),
    .invert_q_i(iq_map[2]), .stb_o(map_stb), .i_o(map_i), .q_o(map_q));

  // DC offset, Q lane strobe unused
  rx_dcoffset #(.WIDTH(DSP_WIDTH), .ALPHA_SHIFT(ALPHA_SHIFT)) u_dco_i (
    .clk(clk), .reset(reset), .set_changed_i(offset_i_changed), .set_value_i(offset_i),
    .stb_i(map_stb), .sample_i(map_i), .stb_o(ofs_stb), .sample_o(ofs_i));

  rx_dcoffset #(.WIDTH(DSP_WIDTH), .ALPHA_SHIFT(ALPHA_SHIFT)) u_dco_q (
    .clk(clk), .reset(reset), .set_changed_i(offset_q_changed), .set_value_i(offset_q),
    .stb_i(map_stb), .sample_i(map_q), .stb_o(), .sample_o(ofs_q));

  // Both lanes scale I: I gets mag_corr, Q gets phase_corr
  rx_iq_comp u_comp_i (
    .clk(clk), .reset(reset), .stb_i(ofs_stb), .a_i(ofs_i), .coef_i(mag_corr),
    .c_i(ofs_i), .stb_o(comp_stb), .sample_o(comp_i));

  rx_iq_comp u_comp_q (
    .clk(clk), .reset(reset), .stb_i(ofs_stb), .a_i(ofs_i), .coef_i(phase_corr),
    .c_i(ofs_q), .stb_o(), .sample_o(comp_q));

  rx_round u_round_i (
    .clk(clk), .reset(reset), .stb_i(comp_stb), .sample_i(comp_i),
    .stb_o(rx_stb_o), .sample_o(rx_i_o));

  rx_round u_round_q (
    .clk(clk), .reset(reset), .stb_i(comp_stb), .sample_i(comp_q),
    .stb_o(), .sample_o(rx_q_o));

endmodule

// File: tb_rx_frontend.sv
/* Receive front end testbench */
`timescale 1ns/1ps

module tb_rx_frontend;

  import rx_frontend_pkg::*;

  localparam int SR_MAG_CORRECTION   = 0;
  localparam int SR_PHASE_CORRECTION = 1;
  localparam int SR_OFFSET_I         = 2;
  localparam int SR_OFFSET_Q         = 3;
  localparam int SR_IQ_MAPPING       = 4;
  localparam int ALPHA_SHIFT         = 12;
  localparam int CLK_PERIOD          = 20;
  localparam int LATENCY             = 5;
  localparam logic [31:0] LFSR_SEED  = 32'he1f2_9753;
  localparam logic [31:0] LFSR_TAPS  = 32'hd000_0001;

  localparam int N_CONV   = 300;
  localparam int N_MAP    = 10;
  localparam int N_OFS    = 32;
  localparam int N_COMP   = 40;
  localparam int N_GAP    = 60;
  localparam int N_STREAM = 60;
  localparam int N_SAMPLES = N_CONV + 16 * N_MAP + N_OFS + N_COMP + N_GAP + N_STREAM + 8;
  localparam int N_WRITES = 48;
  // Gapped samples take up to four cycles each, plus room for the drains
  localparam int TIMEOUT_CYCLES = 4 * (N_SAMPLES + N_WRITES) + 300;

  localparam adc_sample_t CONV_I = 16'sd20000;
  localparam adc_sample_t CONV_Q = -16'sd12000;

  logic        clk;
  logic        reset;
  logic        set_stb_i;
  set_addr_t   set_addr_i;
  set_data_t   set_data_i;
  logic        adc_stb_i;
  adc_sample_t adc_i_i;
  adc_sample_t adc_q_i;
  logic        rx_stb_o;
  adc_sample_t rx_i_o;
  adc_sample_t rx_q_o;

  logic [31:0] lfsr = LFSR_SEED;
  int          err_data = 0;
  int          err_latency = 0;
  int          err_strobe = 0;
  adc_sample_t last_out_i;

  // Reference model state
  longint      mag_m;
  longint      phase_m;
  logic [3:0]  map_m;
  longint      integ_m [2];
  dco_state_t  mode_m [2];
  logic        d1_v;
  logic        d2_v;
  longint      d1_i;
  longint      d1_q;
  longint      d2_i;
  longint      d2_q;
  int          cyc;
  adc_sample_t exp_i_q [$];
  adc_sample_t exp_q_q [$];
  int          stb_cyc_q [$];

  rx_frontend #(
    .SR_MAG_CORRECTION(SR_MAG_CORRECTION), .SR_PHASE_CORRECTION(SR_PHASE_CORRECTION),
    .SR_OFFSET_I(SR_OFFSET_I), .SR_OFFSET_Q(SR_OFFSET_Q),
    .SR_IQ_MAPPING(SR_IQ_MAPPING), .ALPHA_SHIFT(ALPHA_SHIFT)
  ) DUT (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .adc_stb_i(adc_stb_i), .adc_i_i(adc_i_i), .adc_q_i(adc_q_i),
    .rx_stb_o(rx_stb_o), .rx_i_o(rx_i_o), .rx_q_o(rx_q_o));

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // Full-scale values show up about one time in four
  function automatic adc_sample_t rand_sample();
    logic [2:0] pick;
    pick = rand_bits(3);
    if (pick == 3'd0) return 16'sh7fff;
    if (pick == 3'd1) return 16'sh8000;
    return adc_sample_t'(rand_bits(16));
  endfunction

  function automatic set_data_t ofs_word(input logic fixed, input dsp_sample_t ofs);
    return {fixed, 1'b0, ofs, 6'b0};
  endfunction

  function automatic longint clip(input longint v, input int bits);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (bits - 1)) - 1;
    lo = -(longint'(1) <<< (bits - 1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  // Upper 18 bits of a times the Q1.17 coefficient, back to the Q1.23 grid
  function automatic longint comp_value(input longint a, input longint c, input longint coef);
    longint a_top;
    a_top = a >>> 6;
    return clip(c + ((a_top * coef) >>> 11), 24);
  endfunction

  function automatic longint round_value(input longint x);
    return clip((x + 128) >>> 8, 16);
  endfunction

  task automatic apply_write(input set_addr_t addr, input set_data_t data);
    if (addr == SR_MAG_CORRECTION) begin
      mag_m = longint'(coef_t'(data[17:0]));
    end else if (addr == SR_PHASE_CORRECTION) begin
      phase_m = longint'(coef_t'(data[17:0]));
    end else if (addr == SR_IQ_MAPPING) begin
      map_m = data[3:0];
    end else if (addr == SR_OFFSET_I || addr == SR_OFFSET_Q) begin
      integ_m[addr == SR_OFFSET_Q] = longint'(dsp_sample_t'(data[29:6])) <<< ALPHA_SHIFT;
      mode_m[addr == SR_OFFSET_Q] = data[31] ? DCO_FIXED : DCO_TRACK;
    end
  endtask

  // Cycle model: map and offset on entry, compensation two edges later
  always @(posedge clk) begin
    adc_sample_t inv_i;
    adc_sample_t inv_q;
    adc_sample_t mi;
    adc_sample_t mq;
    longint      lane [2];
    if (reset) begin
      mag_m = 0;
      phase_m = 0;
      map_m = '0;
      integ_m = '{0, 0};
      mode_m = '{DCO_TRACK, DCO_TRACK};
      d1_v = 1'b0;
      d2_v = 1'b0;
      cyc = 0;
    end else begin
      cyc = cyc + 1;
      if (d2_v) begin
        exp_i_q.push_back(adc_sample_t'(round_value(comp_value(d2_i, d2_i, mag_m))));
        exp_q_q.push_back(adc_sample_t'(round_value(comp_value(d2_i, d2_q, phase_m))));
      end
      d2_v = d1_v;
      d2_i = d1_i;
      d2_q = d1_q;
      d1_v = adc_stb_i;
      if (adc_stb_i) begin
        inv_i = map_m[3] ? ~adc_i_i : adc_i_i;
        inv_q = map_m[2] ? ~adc_q_i : adc_q_i;
        mi = map_m[0] ? inv_q : inv_i;
        mq = map_m[1] ? '0 : (map_m[0] ? inv_i : inv_q);
        lane[0] = longint'(mi) * 256;
        lane[1] = longint'(mq) * 256;
        for (int ln = 0; ln < 2; ln++) begin
          lane[ln] = clip(lane[ln] - (integ_m[ln] >>> ALPHA_SHIFT), 24);
          if (mode_m[ln] == DCO_TRACK) begin
            integ_m[ln] = integ_m[ln] + lane[ln];
          end
        end
        d1_i = lane[0];
        d1_q = lane[1];
        stb_cyc_q.push_back(cyc);
      end
      // A write is seen from the next edge on
      if (set_stb_i) begin
        apply_write(set_addr_i, set_data_i);
      end
    end
  end

  // Output checks away from the active edge
  // An output seen here is taken at the next active edge, cycle cyc + 1
  always @(negedge clk) begin
    int          entry;
    adc_sample_t want_i;
    adc_sample_t want_q;
    if (!reset) begin
      if (stb_cyc_q.size() != 0 && cyc + 1 - stb_cyc_q[0] > LATENCY) begin
        err_strobe++;
        $display("Sample taken in cycle %0d gave no output strobe", stb_cyc_q[0]);
        void'(stb_cyc_q.pop_front());
        if (exp_i_q.size() != 0) begin
          void'(exp_i_q.pop_front());
          void'(exp_q_q.pop_front());
        end
      end
      if (rx_stb_o) begin
        assert (stb_cyc_q.size() != 0) else begin
          err_strobe++;
          $display("Output strobe at %0t ns with no sample in flight", $time);
        end
        if (stb_cyc_q.size() != 0) begin
          entry = stb_cyc_q.pop_front();
          assert (cyc + 1 - entry == LATENCY) else begin
            err_latency++;
            $display("** Error at %0t ns: latency %0d cycles, expected %0d",
                     $time, cyc + 1 - entry, LATENCY);
          end
        end
        if (exp_i_q.size() != 0) begin
          want_i = exp_i_q.pop_front();
          want_q = exp_q_q.pop_front();
          assert (rx_i_o == want_i && rx_q_o == want_q) else begin
            err_data++;
            $display("** Error at %0t ns: output I %0d Q %0d, expected I %0d Q %0d",
                     $time, rx_i_o, rx_q_o, want_i, want_q);
          end
        end
        last_out_i = rx_i_o;
      end
    end
  end

  task automatic drive_cycle(input logic stb, input adc_sample_t i_val,
                             input adc_sample_t q_val, input logic wr,
                             input set_addr_t addr, input set_data_t data);
    @(negedge clk);
    adc_stb_i = stb;
    adc_i_i = i_val;
    adc_q_i = q_val;
    set_stb_i = wr;
    set_addr_i = addr;
    set_data_i = data;
  endtask

  task automatic send_sample(input adc_sample_t i_val, input adc_sample_t q_val);
    drive_cycle(1'b1, i_val, q_val, 1'b0, '0, '0);
  endtask

  task automatic write_reg(input int addr, input set_data_t data);
    drive_cycle(1'b0, '0, '0, 1'b1, set_addr_t'(addr), data);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  // Wait until every sample in flight has come out
  task automatic drain();
    while (stb_cyc_q.size() != 0) begin
      idle(1);
    end
    idle(3);
  endtask

  task automatic tracking_from_reset();
    send_sample(CONV_I, CONV_Q);
    do begin
      idle(1);
    end while (!rx_stb_o);
    assert (rx_i_o == CONV_I && rx_q_o == CONV_Q) else begin
      err_data++;
      $display("** Error at %0t ns: first sample I %0d Q %0d, expected I %0d Q %0d",
               $time, rx_i_o, rx_q_o, CONV_I, CONV_Q);
    end
    repeat (N_CONV - 1) send_sample(CONV_I, CONV_Q);
    drain();
    assert (last_out_i < CONV_I) else begin
      err_data++;
      $display("** Error at %0t ns: I offset did not decay, last output %0d",
               $time, last_out_i);
    end
  endtask

  task automatic mapping_modes();
    write_reg(SR_OFFSET_I, ofs_word(1'b1, '0));
    write_reg(SR_OFFSET_Q, ofs_word(1'b1, '0));
    for (int m = 0; m < 16; m++) begin
      write_reg(SR_IQ_MAPPING, set_data_t'(m));
      repeat (N_MAP) send_sample(rand_sample(), rand_sample());
    end
    write_reg(SR_IQ_MAPPING, '0);
    drain();
  endtask

  task automatic fixed_offsets();
    write_reg(SR_OFFSET_I, ofs_word(1'b1, 24'sh400000));
    write_reg(SR_OFFSET_Q, ofs_word(1'b1, -24'sh400000));
    send_sample(16'sh8000, 16'sh7fff);
    send_sample(16'sh7fff, 16'sh8000);
    write_reg(SR_OFFSET_I, ofs_word(1'b1, -24'sh400000));
    write_reg(SR_OFFSET_Q, ofs_word(1'b1, 24'sh400000));
    send_sample(16'sh7fff, 16'sh8000);
    send_sample(16'sh8000, 16'sh7fff);
    repeat (4) begin
      write_reg(SR_OFFSET_I, ofs_word(1'b1, dsp_sample_t'(rand_bits(24))));
      write_reg(SR_OFFSET_Q, ofs_word(1'b1, dsp_sample_t'(rand_bits(24))));
      repeat (N_OFS / 4) send_sample(rand_sample(), rand_sample());
    end
    drain();
  endtask

  task automatic imbalance_correction();
    write_reg(SR_OFFSET_I, ofs_word(1'b1, '0));
    write_reg(SR_OFFSET_Q, ofs_word(1'b1, '0));
    repeat (4) begin
      write_reg(SR_MAG_CORRECTION, rand_bits(18));
      write_reg(SR_PHASE_CORRECTION, rand_bits(18));
      repeat (N_COMP / 4) send_sample(rand_sample(), rand_sample());
    end
    // Largest coefficients drive the sum into clipping
    write_reg(SR_MAG_CORRECTION, 32'h1ffff);
    write_reg(SR_PHASE_CORRECTION, 32'h20000);
    send_sample(16'sh7fff, 16'sh7fff);
    send_sample(16'sh8000, 16'sh8000);
    send_sample(16'sh7fff, 16'sh8000);
    send_sample(16'sh8000, 16'sh7fff);
    write_reg(SR_MAG_CORRECTION, '0);
    write_reg(SR_PHASE_CORRECTION, '0);
    drain();
  endtask

  task automatic gapped_strobes();
    write_reg(SR_OFFSET_I, ofs_word(1'b0, dsp_sample_t'(rand_bits(24))));
    write_reg(SR_OFFSET_Q, ofs_word(1'b0, dsp_sample_t'(rand_bits(24))));
    write_reg(SR_MAG_CORRECTION, rand_bits(18));
    write_reg(SR_PHASE_CORRECTION, rand_bits(18));
    repeat (N_GAP) begin
      send_sample(rand_sample(), rand_sample());
      idle(int'(rand_bits(2)));
    end
    drain();
  endtask

  // Addresses 0 to 4 cover the five registers
  task automatic writes_mid_stream();
    for (int k = 0; k < N_STREAM; k++) begin
      if (k % 8 == 4) begin
        drive_cycle(1'b1, rand_sample(), rand_sample(), 1'b1,
                    set_addr_t'((k / 8) % 5), rand_bits(32));
      end else begin
        send_sample(rand_sample(), rand_sample());
      end
    end
    drain();
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    set_stb_i = 1'b0;
    set_addr_i = '0;
    set_data_i = '0;
    adc_stb_i = 1'b0;
    adc_i_i = '0;
    adc_q_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    tracking_from_reset();
    mapping_modes();
    fixed_offsets();
    imbalance_correction();
    gapped_strobes();
    writes_mid_stream();
    $display("Errors: data %0d, latency %0d, strobe %0d", err_data, err_latency, err_strobe);
    if (err_data + err_latency + err_strobe == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// File: sources.f
rx_frontend_pkg.sv
setting_reg.sv
rx_iq_map.sv
rx_dcoffset.sv
rx_iq_comp.sv
rx_round.sv
rx_frontend.sv
tb_rx_frontend.sv

// File: Makefile
# Verilator build and run of the receive front end testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_frontend
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= test failed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_TEXT"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
